/* common/sync_shape_pkg.sv */
/*
 * Shared types and default sizes for the activation shape synchronizer.
 * Modules pull these in with a wildcard import in their header.
 */

package sync_shape_pkg;

    // ============================================================
    // Activation data
    // ============================================================

    // Width of one activation element
    localparam int ACT_W = 8;

    // One activation, as seen on a single row of the array edge
    typedef logic [ACT_W-1:0] act_t;

    // ============================================================
    // Default sizes
    // ============================================================

    // Independent banks at the array edge
    localparam int DEF_NUM_BANK = 4;

    // Rows per activation vector
    localparam int DEF_NUM_ROW = 16;

    // RAM address width, depth is 2**DEF_ADDR_WIDTH
    // Depth must cover at least one full skew window of NUM_ROW words
    localparam int DEF_ADDR_WIDTH = 4;

    // ============================================================
    // Output stage of a row RAM
    // ============================================================

    // RD_IDLE: nothing held
    // RD_HOLD: read word parked until the consumer takes it
    typedef enum logic {
        RD_IDLE = 1'b0,
        RD_HOLD = 1'b1
    } rd_state_e;

endpackage : sync_shape_pkg

/* rtl/sync_shape/shape_ram.sv */
/*
 * Row RAM of one bank: one write port, one registered read port.
 * The read word sits in an output register under valid/ready until taken.
 * A new read may only be issued when the output stage is free or drained.
 */

`timescale 1ns/1ps

module shape_ram
    import sync_shape_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear_i,
    // Write port
    input  logic                  wr_en_i,
    input  logic [ADDR_WIDTH-1:0] wr_addr_i,
    input  act_t                  wr_data_i,
    // Read request
    input  logic                  rd_req_i,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,
    // Read data out, valid/ready
    input  logic                  rd_rdy_i,
    output act_t                  rd_data_o,
    output logic                  rd_vld_o
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    // ============================================================
    // Storage
    // ============================================================

    act_t      mem [DEPTH];
    act_t      rd_data_q;
    rd_state_e state_q;

    // Plain write, no read-during-write bypass needed
    // (bank never reads a slot on the cycle it writes it)
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Registered read, doubles as the hold register
    always_ff @(posedge clk) begin
        if (rd_req_i) begin
            rd_data_q <= mem[rd_addr_i];
        end
    end

    // ============================================================
    // Output stage
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= RD_IDLE;
        end else if (clear_i) begin
            state_q <= RD_IDLE;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (rd_req_i) begin
                        state_q <= RD_HOLD;
                    end
                end
                RD_HOLD: begin
                    // Taken and no refill behind it
                    if (rd_rdy_i && !rd_req_i) begin
                        state_q <= RD_IDLE;
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    assign rd_data_o = rd_data_q;
    assign rd_vld_o  = (state_q == RD_HOLD);

    // A held word must not be overwritten by a new read
    assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == RD_HOLD && !rd_rdy_i) |-> !rd_req_i)
        else $error("shape_ram: read issued over a held word");

endmodule : shape_ram

/* rtl/sync_shape/shape_bank.sv */
/*
 * One bank of the shape synchronizer.
 * Row j of each input vector goes to its own RAM at the write pointer minus j,
 * all rows are read at one common read pointer, which removes the diagonal skew.
 * A word is read once NUM_ROW vectors are pending; input stalls at full depth.
 */

`timescale 1ns/1ps

module shape_bank
    import sync_shape_pkg::*;
#(
    parameter int NUM_ROW    = DEF_NUM_ROW,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clear_i,
    // Skewed input vectors
    input  act_t [NUM_ROW-1:0]        din_data_i,
    input  logic                      din_vld_i,
    output logic                      din_rdy_o,
    // Aligned output words
    output act_t [NUM_ROW-1:0]        out_data_o,
    output logic                      out_vld_o,
    input  logic                      out_rdy_i
);

    // ============================================================
    // Sizes
    // ============================================================

    // RAM depth in words
    localparam int DEPTH = 1 << ADDR_WIDTH;
    // Pending counter must reach DEPTH itself
    localparam int CNT_W = ADDR_WIDTH + 1;

    // ============================================================
    // Control state
    // ============================================================

    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    // Vectors written minus words read
    logic [CNT_W-1:0]      pending;

    logic                  full;
    logic                  push;
    logic                  pop;

    // Per-row write address and read valid
    logic [ADDR_WIDTH-1:0] wr_addr [NUM_ROW];
    logic [NUM_ROW-1:0]    row_vld;

    // Full once every slot of the depth holds a pending word
    assign full      = (pending == CNT_W'(DEPTH));
    assign din_rdy_o = !full;
    assign push      = din_vld_i && din_rdy_o;

    // Enough vectors for a complete word, and the output stage
    // is empty or being taken on this edge
    assign pop = (pending >= CNT_W'(NUM_ROW)) && (!out_vld_o || out_rdy_i);

    // Rows share their controls so the valids move in lockstep
    assign out_vld_o = &row_vld;

    // Write pointer steps once per accepted vector
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Read pointer steps once per issued read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (clear_i) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Pending count holds when push and pop coincide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (clear_i) begin
            pending <= '0;
        end else if (push && !pop) begin
            pending <= pending + 1'b1;
        end else if (pop && !push) begin
            pending <= pending - 1'b1;
        end
    end

    // ============================================================
    // Row RAMs
    // ============================================================

    for (genvar j = 0; j < NUM_ROW; j++) begin : g_row

        // Row j of vector m lands in slot m-j
        // so word k collects row j from vector k+j
        assign wr_addr[j] = wr_ptr - ADDR_WIDTH'(j);

        shape_ram #(
            .ADDR_WIDTH (ADDR_WIDTH)
        ) i_ram (
            .clk       (clk),
            .rst_n     (rst_n),
            .clear_i   (clear_i),
            .wr_en_i   (push),
            .wr_addr_i (wr_addr[j]),
            .wr_data_i (din_data_i[j]),
            .rd_req_i  (pop),
            .rd_addr_i (rd_ptr),
            .rd_rdy_i  (out_rdy_i),
            .rd_data_o (out_data_o[j]),
            .rd_vld_o  (row_vld[j])
        );
    end

    // ============================================================
    // Checks
    // ============================================================

    // Counter never runs past the RAM depth
    assert property (@(posedge clk) disable iff (!rst_n)
        pending <= CNT_W'(DEPTH))
        else $error("shape_bank: pending count above depth");

    // Pointers meet with words pending only when the RAM is full
    // so a push there would overwrite an unread slot
    assert property (@(posedge clk) disable iff (!rst_n)
        (push && pending != '0) |-> (wr_ptr != rd_ptr))
        else $error("shape_bank: vector accepted while full");

    // Depth must hold a whole skew window
    assert property (@(posedge clk) DEPTH >= NUM_ROW)
        else $error("shape_bank: RAM depth below NUM_ROW");

endmodule : shape_bank

/* rtl/sync_shape.sv */
/*
 * Top of the activation shape synchronizer.
 * Holds NUM_BANK independent banks, each de-skewing one stream of
 * NUM_ROW-wide activation vectors with its own valid/ready on both sides.
 */

`timescale 1ns/1ps

module sync_shape
    import sync_shape_pkg::*;
#(
    parameter int NUM_BANK   = DEF_NUM_BANK,
    parameter int NUM_ROW    = DEF_NUM_ROW,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // Empties every bank
    input  logic                              clear_i,

    // ============================================================
    // Input side, skewed vectors
    // ============================================================

    input  act_t [NUM_BANK-1:0][NUM_ROW-1:0]  din_data_i,
    input  logic [NUM_BANK-1:0]               din_vld_i,
    output logic [NUM_BANK-1:0]               din_rdy_o,

    // ============================================================
    // Output side, aligned words
    // ============================================================

    output act_t [NUM_BANK-1:0][NUM_ROW-1:0]  out_data_o,
    output logic [NUM_BANK-1:0]               out_vld_o,
    input  logic [NUM_BANK-1:0]               out_rdy_i
);

    // One bank per slice
    // Banks share only clock, reset and clear
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank

        shape_bank #(
            .NUM_ROW    (NUM_ROW),
            .ADDR_WIDTH (ADDR_WIDTH)
        ) i_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .clear_i    (clear_i),
            .din_data_i (din_data_i[b]),
            .din_vld_i  (din_vld_i[b]),
            .din_rdy_o  (din_rdy_o[b]),
            .out_data_o (out_data_o[b]),
            .out_vld_o  (out_vld_o[b]),
            .out_rdy_i  (out_rdy_i[b])
        );
    end

endmodule : sync_shape

/* sim/tb_clk_gen.sv */
/*
 * Testbench clock and reset source.
 * 8 ns clock, active-low reset held for the first 5 rising edges.
 */

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD = 4,
    parameter int RST_CYCLES  = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule : tb_clk_gen

/* sim/tb_sync_shape.sv */
/*
 * Testbench top for the shape synchronizer.
 * Directed tests per task; a per-bank model of accepted vectors
 * predicts every aligned output word from the de-skew rule.
 */

`timescale 1ns/1ps

module tb_sync_shape
    import sync_shape_pkg::*;
();

    localparam int NUM_BANK    = DEF_NUM_BANK;
    localparam int NUM_ROW     = DEF_NUM_ROW;
    localparam int DEPTH       = 1 << DEF_ADDR_WIDTH;
    localparam int MAX_VEC     = 256;
    localparam int WAIT_CYC    = 200;
    localparam int STREAM_LEN  = 48;
    // About twice the summed test lengths
    localparam int TIMEOUT_CYC = 4000;

    typedef act_t [NUM_ROW-1:0] vec_t;

    logic                             clk;
    logic                             rst_n;
    logic                             clear;
    act_t [NUM_BANK-1:0][NUM_ROW-1:0] din_data;
    logic [NUM_BANK-1:0]              din_vld;
    logic [NUM_BANK-1:0]              din_rdy;
    act_t [NUM_BANK-1:0][NUM_ROW-1:0] out_data;
    logic [NUM_BANK-1:0]              out_vld;
    logic [NUM_BANK-1:0]              out_rdy;

    // Model state per bank
    vec_t acc_mem [NUM_BANK][MAX_VEC];
    int   acc_cnt [NUM_BANK];
    int   out_cnt [NUM_BANK];
    int   acc_full_cyc [NUM_BANK];
    int   first_vld_cyc [NUM_BANK];
    int   cyc;
    int   val_errs;
    int   other_errs;
    int   seed;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    sync_shape #(
        .NUM_BANK   (NUM_BANK),
        .NUM_ROW    (NUM_ROW),
        .ADDR_WIDTH (DEF_ADDR_WIDTH)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear_i    (clear),
        .din_data_i (din_data),
        .din_vld_i  (din_vld),
        .din_rdy_o  (din_rdy),
        .out_data_o (out_data),
        .out_vld_o  (out_vld),
        .out_rdy_i  (out_rdy)
    );

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic check_word(input act_t actual, input act_t expected,
                              input int bank, input int row, input string what);
        if (actual !== expected) begin
            val_errs++;
            $display("[FAIL] t=%0t bank %0d row %0d: %s got %h expected %h",
                     $time, bank, row, what, actual, expected);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected,
                             input int bank, input string what);
        if (actual !== expected) begin
            val_errs++;
            $display("[FAIL] t=%0t bank %0d: %s got %b expected %b",
                     $time, bank, what, actual, expected);
        end
    endtask

    task automatic check_count(input int actual, input int expected,
                               input int bank, input string what);
        if (actual != expected) begin
            val_errs++;
            $display("[FAIL] t=%0t bank %0d: %s got %0d expected %0d",
                     $time, bank, what, actual, expected);
        end
    endtask

    // ============================================================
    // Reference model
    // ============================================================

    task automatic reset_model();
        for (int b = 0; b < NUM_BANK; b++) begin
            acc_cnt[b]       = 0;
            out_cnt[b]       = 0;
            acc_full_cyc[b]  = -1;
            first_vld_cyc[b] = -1;
        end
    endtask

    // Word k holds row j of accepted vector k+j
    task automatic check_output(input int bank);
        int k;
        k = out_cnt[bank];
        if (k + NUM_ROW > acc_cnt[bank]) begin
            other_errs++;
            $display("Bank %0d produced word %0d with only %0d vectors accepted",
                     bank, k, acc_cnt[bank]);
        end else begin
            for (int j = 0; j < NUM_ROW; j++) begin
                check_word(out_data[bank][j], acc_mem[bank][k + j][j], bank, j, "output word");
            end
        end
        out_cnt[bank]++;
    endtask

    task automatic record_input(input int bank);
        if (acc_cnt[bank] < MAX_VEC) begin
            acc_mem[bank][acc_cnt[bank]] = din_data[bank];
            acc_cnt[bank]++;
        end else begin
            other_errs++;
            $display("Bank %0d accepted more vectors than the model can store", bank);
        end
        if (acc_cnt[bank] == NUM_ROW) begin
            acc_full_cyc[bank] = cyc;
        end
    endtask

    // Words a bank can produce from its accepted vectors
    function automatic int expected_words(input int bank);
        return (acc_cnt[bank] >= NUM_ROW) ? acc_cnt[bank] - NUM_ROW + 1 : 0;
    endfunction

    // Samples pre-edge values before the DUT flops update
    always @(posedge clk) begin
        cyc++;
        if (clear) begin
            reset_model();
        end else if (rst_n) begin
            for (int b = 0; b < NUM_BANK; b++) begin
                if (out_vld[b] && first_vld_cyc[b] < 0) begin
                    first_vld_cyc[b] = cyc;
                end
                if (out_vld[b] && out_rdy[b]) begin
                    check_output(b);
                end
                if (din_vld[b] && din_rdy[b]) begin
                    record_input(b);
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYC);
        $display("Verification failed");
        $finish;
    end

    // ============================================================
    // Drive helpers
    // ============================================================

    // Inputs change 1 ns after the edge
    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Also reports which banks accepted a vector on the edge
    task automatic next_cycle(output logic [NUM_BANK-1:0] acc);
        @(posedge clk);
        acc = din_vld & din_rdy;
        #1;
    endtask

    function automatic vec_t rand_vec();
        vec_t v;
        for (int j = 0; j < NUM_ROW; j++) begin
            v[j] = act_t'($random(seed));
        end
        return v;
    endfunction

    // Valid is held until taken
    // Gives up after idle_max cycles without a transfer
    task automatic push_vectors(input int bank, input int n, input int idle_max,
                                output int sent);
        logic [NUM_BANK-1:0] acc;
        int idle;
        sent = 0;
        idle = 0;
        din_data[bank] = rand_vec();
        din_vld[bank]  = 1'b1;
        while (sent < n && idle < idle_max) begin
            next_cycle(acc);
            if (acc[bank]) begin
                sent++;
                idle = 0;
                din_data[bank] = rand_vec();
            end else begin
                idle++;
            end
        end
        din_vld[bank] = 1'b0;
    endtask

    // Waits for every predicted word with ready high
    task automatic wait_drain(input int bank);
        int waited;
        waited = 0;
        while (out_cnt[bank] < expected_words(bank) && waited < WAIT_CYC) begin
            tick(1);
            waited++;
        end
        if (out_cnt[bank] < expected_words(bank)) begin
            other_errs++;
            $display("Bank %0d is missing %0d output words",
                     bank, expected_words(bank) - out_cnt[bank]);
        end
        tick(4);
        check_bit(out_vld[bank], 1'b0, bank, "out_vld after drain");
        check_count(out_cnt[bank], expected_words(bank), bank, "output word count");
    endtask

    task automatic clear_banks();
        din_vld = '0;
        out_rdy = '0;
        clear   = 1'b1;
        tick(1);
        clear = 1'b0;
        for (int b = 0; b < NUM_BANK; b++) begin
            check_bit(out_vld[b], 1'b0, b, "out_vld after clear");
            check_bit(din_rdy[b], 1'b1, b, "din_rdy after clear");
        end
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic test_partial_window();
        int sent;
        for (int b = 0; b < NUM_BANK; b++) begin
            check_bit(out_vld[b], 1'b0, b, "out_vld after reset");
            check_bit(din_rdy[b], 1'b1, b, "din_rdy after reset");
        end
        // One vector short of a full window on every bank
        out_rdy = '1;
        for (int b = 0; b < NUM_BANK; b++) begin
            push_vectors(b, NUM_ROW - 1, WAIT_CYC, sent);
            check_count(sent, NUM_ROW - 1, b, "accepted vectors");
        end
        tick(10);
        for (int b = 0; b < NUM_BANK; b++) begin
            check_bit(out_vld[b], 1'b0, b, "out_vld with a partial window");
            check_count(out_cnt[b], 0, b, "words from a partial window");
        end
        clear_banks();
    endtask

    task automatic test_steady_stream();
        int sent;
        out_rdy[0] = 1'b1;
        push_vectors(0, 40, WAIT_CYC, sent);
        check_count(sent, 40, 0, "accepted vectors");
        wait_drain(0);
        // Read issued on the edge after the window fills
        // Valid seen one edge later
        check_count(first_vld_cyc[0] - acc_full_cyc[0], 2, 0, "first output latency");
        clear_banks();
    endtask

    task automatic test_back_pressure();
        vec_t held;
        int   sent;
        out_rdy = '0;
        push_vectors(1, DEPTH + 4, 8, sent);
        // Full RAM plus the word parked in the output stage
        check_count(sent, DEPTH + 1, 1, "vectors accepted under back-pressure");
        check_bit(din_rdy[1], 1'b0, 1, "din_rdy when full");
        check_bit(out_vld[1], 1'b1, 1, "out_vld under back-pressure");
        held = out_data[1];
        repeat (6) begin
            tick(1);
            check_bit(out_vld[1], 1'b1, 1, "out_vld while held");
            for (int j = 0; j < NUM_ROW; j++) begin
                check_word(out_data[1][j], held[j], 1, j, "held word");
            end
        end
        out_rdy[1] = 1'b1;
        wait_drain(1);
        clear_banks();
    endtask

    task automatic test_all_banks();
        logic [NUM_BANK-1:0] acc;
        int   sent [NUM_BANK];
        int   loops;
        logic busy;
        for (int b = 0; b < NUM_BANK; b++) begin
            sent[b] = 0;
        end
        loops = 0;
        busy  = 1'b1;
        while (busy && loops < 1500) begin
            for (int b = 0; b < NUM_BANK; b++) begin
                // Random gaps between vectors
                // Valid never drops before its transfer
                if (!din_vld[b] && sent[b] < STREAM_LEN && ($random(seed) % 4) != 0) begin
                    din_data[b] = rand_vec();
                    din_vld[b]  = 1'b1;
                end
                out_rdy[b] = (($random(seed) & 1) == 1);
            end
            next_cycle(acc);
            loops++;
            busy = 1'b0;
            for (int b = 0; b < NUM_BANK; b++) begin
                if (acc[b]) begin
                    sent[b]++;
                    din_vld[b] = 1'b0;
                end
                if (sent[b] < STREAM_LEN) begin
                    busy = 1'b1;
                end
            end
        end
        din_vld = '0;
        out_rdy = '1;
        for (int b = 0; b < NUM_BANK; b++) begin
            check_count(sent[b], STREAM_LEN, b, "accepted vectors");
            wait_drain(b);
        end
        clear_banks();
    endtask

    task automatic test_mid_clear();
        int sent;
        // Old stream leaves a held word and a full RAM behind
        out_rdy = '0;
        push_vectors(2, DEPTH + 1, 8, sent);
        check_bit(out_vld[2], 1'b1, 2, "out_vld before clear");
        clear_banks();
        out_rdy[2] = 1'b1;
        push_vectors(2, 20, WAIT_CYC, sent);
        check_count(sent, 20, 2, "accepted vectors after clear");
        wait_drain(2);
        clear_banks();
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        seed       = 32'h1d2b8e70;
        cyc        = 0;
        val_errs   = 0;
        other_errs = 0;
        clear      = 1'b0;
        din_data   = '0;
        din_vld    = '0;
        out_rdy    = '0;
        reset_model();
        wait (rst_n === 1'b1);
        tick(1);
        test_partial_window();
        test_steady_stream();
        test_back_pressure();
        test_all_banks();
        test_mid_clear();
        $display("Errors: %0d value mismatches, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_sync_shape

/* all.f */
common/sync_shape_pkg.sv
rtl/sync_shape/shape_ram.sv
rtl/sync_shape/shape_bank.sv
rtl/sync_shape.sv
sim/tb_clk_gen.sv
sim/tb_sync_shape.sv
